// ==== trigger_top.f ====
verilog/trigger_pkg.sv
verilog/trigger_fifo.sv
verilog/ttc_trigger_receiver.sv
verilog/channel_acq_controller.sv
verilog/trigger_processor.sv
verilog/trigger_top.sv
dv/trigger_top_assert.sv
dv/trigger_top_tb.sv

// ==== dv/trigger_top_tb.sv ====
// trigger manager testbench
`timescale 1ns/1ps
`default_nettype none

module trigger_top_tb;

    import trigger_pkg::*;

    localparam int TIMEOUT    = 400;  // cycles per wait loop
    localparam int FIFO_DEPTH = 4;    // small, a held readout fills both fifos

    typedef struct packed {
        trig_num_t  glob_before;  // counters seen before this trigger
        trig_num_t  evt_before;
        trig_type_t trig_type;
        chan_mask_t mask;
    } stim_t;

    typedef struct packed {
        int         cycle;  // negedge count where chan_trig shows
        chan_mask_t mask;
    } fire_t;

    logic       ttc_clk = 1'b0;
    logic       rst;
    logic       rst_trigger_num;
    logic       ttc_trigger;
    trig_type_t trig_type;
    chan_mask_t chan_en;
    delay_t     trig_delay;
    chan_mask_t chan_dones;
    chan_mask_t chan_enable;
    chan_mask_t chan_trig;
    logic       readout_ready;
    logic       readout_done;
    logic       initiate_readout;
    logic       send_empty_event;
    trig_info_t readout_info;
    trig_num_t  trig_num;
    logic       trig_fifo_full;
    logic       acq_fifo_full;
    logic       error_trig_rate;
    logic       error_trig_num;
    logic       error_trig_type;

    int         seed;
    int         cycle = 0;        // posedges so far
    int         readout_cnt = 0;
    int         chan_lat;
    int         cm_lat;
    int         i;
    int         t;
    trig_num_t  glob_cnt;         // model counters
    trig_num_t  evt_cnt;
    logic       rate_err_exp;
    timestamp_t last_ts;
    stim_t      stim_q[$];        // accepted triggers, oldest first
    fire_t      fire_q[$];
    stim_t      cur_stim;
    fire_t      cur_fire;
    trig_info_t exp_info;
    logic       exp_empty;
    trig_type_t type_list[4] = '{TRIG_MUON_FILL, TRIG_LASER, TRIG_PEDESTAL, TRIG_ASYNC_READOUT};

    trigger_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

    always #2 ttc_clk = ~ttc_clk;  // 4 ns period
    always @(posedge ttc_clk) cycle <= cycle + 1;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at first error");
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_readout(input trig_info_t got, input trig_info_t exp);
        if (got.trig_num != exp.trig_num || got.event_num != exp.event_num
                || got.trig_type != exp.trig_type)
            abort_run($sformatf(
                "Error at %0t ns: readout num %0d evt %0d type %0d, expected %0d %0d %0d",
                $time, got.trig_num, got.event_num, got.trig_type,
                exp.trig_num, exp.event_num, exp.trig_type));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp)
            abort_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_mask(input chan_mask_t got, input chan_mask_t exp, input string name);
        if (got !== exp)
            abort_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input trig_num_t got, input trig_num_t exp, input string name);
        if (got !== exp)
            abort_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                $time, name, got, exp));
    endtask

    // expected descriptor from the counting rules
    function automatic trig_info_t predict_readout(input stim_t s, output logic empty);
        trig_info_t e;
        e.timestamp = '0;                    // order only, checked apart
        e.trig_num  = s.glob_before + 1'b1;  // every trigger counts
        e.event_num = s.evt_before + 1'b1;   // accepted ones only
        e.trig_type = s.trig_type;
        empty       = (s.mask == '0);
        return e;
    endfunction

    function automatic trig_type_t pick_type();
        return type_list[$unsigned($random(seed)) % 4];
    endfunction

    function automatic chan_mask_t pick_mask();
        chan_mask_t m;
        m = chan_mask_t'($random(seed));
        if (m == '0) m = 5'b00001;  // keep it non-empty
        return m;
    endfunction

    // one-cycle trigger, called on a falling edge
    task automatic send_trigger(input trig_type_t ty, input chan_mask_t mask, input logic drop);
        stim_t s;
        fire_t f;
        s.glob_before = glob_cnt;
        s.evt_before  = evt_cnt;
        s.trig_type   = ty;
        s.mask        = mask;
        ttc_trigger   = 1'b1;
        trig_type     = ty;
        chan_en       = mask;
        glob_cnt      = glob_cnt + 1'b1;
        if (drop) begin
            rate_err_exp = 1'b1;  // sticky until rst
        end else begin
            evt_cnt = evt_cnt + 1'b1;
            stim_q.push_back(s);
            if (mask != '0) begin
                f.cycle = cycle + int'(trig_delay) + 2;
                f.mask  = mask;
                fire_q.push_back(f);
            end
        end
        @(negedge ttc_clk);
        ttc_trigger = 1'b0;
        check_count(trig_num, glob_cnt, "trig_num");  // counted on the sampling edge
    endtask

    task automatic wait_readouts(input int n);
        int k;
        for (k = 0; k < TIMEOUT && readout_cnt < n; k++) @(negedge ttc_clk);
        if (readout_cnt < n) abort_run("timed out waiting for a readout request");
    endtask

    // channels taken, then released
    task automatic wait_acq_done();
        int k;
        for (k = 0; k < TIMEOUT && chan_enable == '0; k++) @(negedge ttc_clk);
        if (chan_enable == '0) abort_run("channels were never enabled");
        for (k = 0; k < TIMEOUT && chan_enable != '0; k++) @(negedge ttc_clk);
        if (chan_enable != '0) abort_run("acquisition never completed");
    endtask

    // --------------------
    // channel and command manager models
    // --------------------
    always begin : channel_model
        @(negedge ttc_clk);
        if (chan_trig != '0) begin
            chan_lat = 1 + ($unsigned($random(seed)) % 8);
            repeat (chan_lat) @(negedge ttc_clk);
            chan_dones = chan_enable;  // enabled channels report
            for (t = 0; t < TIMEOUT && chan_enable != '0; t++) @(negedge ttc_clk);
            if (chan_enable != '0) abort_run("channel enables never cleared");
            chan_dones = '0;
        end
    end

    always begin : command_manager
        @(negedge ttc_clk);
        if (initiate_readout || send_empty_event) begin
            cm_lat = 2 + ($unsigned($random(seed)) % 9);
            repeat (cm_lat) @(negedge ttc_clk);
            readout_done = 1'b1;
            @(negedge ttc_clk);
            readout_done = 1'b0;
        end
    end

    // compare on the falling edge, outputs settled
    always @(negedge ttc_clk) begin : compare
        if (!rst) begin
            if (i_dut.i_assert.fail_count != 0) abort_run("a port assertion failed");
            if (chan_trig != '0) begin
                if (fire_q.size() == 0) abort_run("chan_trig pulsed with no trigger pending");
                cur_fire = fire_q.pop_front();
                check_mask(chan_trig, cur_fire.mask, "chan_trig");
                check_mask(chan_enable, cur_fire.mask, "chan_enable");
                if (cycle != cur_fire.cycle)
                    abort_run($sformatf("Error at %0t ns: chan_trig at cycle %0d, expected %0d",
                        $time, cycle, cur_fire.cycle));
            end
            if (initiate_readout || send_empty_event) begin
                if (stim_q.size() == 0) abort_run("readout request with no trigger pending");
                cur_stim = stim_q.pop_front();
                exp_info = predict_readout(cur_stim, exp_empty);
                check_readout(readout_info, exp_info);
                check_flag(send_empty_event, exp_empty, "send_empty_event");
                check_flag(error_trig_rate, rate_err_exp, "error_trig_rate");
                check_flag(error_trig_num, 1'b0, "error_trig_num");
                check_flag(error_trig_type, 1'b0, "error_trig_type");
                if (readout_info.timestamp <= last_ts)
                    abort_run($sformatf("Error at %0t ns: timestamp %0d not above %0d",
                        $time, readout_info.timestamp, last_ts));
                last_ts     = readout_info.timestamp;
                readout_cnt = readout_cnt + 1;
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        seed            = 43184;
        rst             = 1'b1;
        rst_trigger_num = 1'b0;
        ttc_trigger     = 1'b0;
        trig_type       = TRIG_MUON_FILL;
        chan_en         = '0;
        trig_delay      = delay_t'(3);
        chan_dones      = '0;
        readout_ready   = 1'b1;
        readout_done    = 1'b0;
        glob_cnt        = '0;
        evt_cnt         = '0;
        rate_err_exp    = 1'b0;
        last_ts         = '0;
        repeat (4) @(negedge ttc_clk);
        rst = 1'b0;
        repeat (3) @(negedge ttc_clk);

        for (i = 0; i < 6; i++) begin  // spaced, delay 0 to 5
            trig_delay = delay_t'(i);
            send_trigger(pick_type(), pick_mask(), 1'b0);
            wait_readouts(i + 1);
        end
        send_trigger(TRIG_PEDESTAL, '0, 1'b0);  // no channels
        wait_readouts(7);

        trig_delay = delay_t'(4);
        send_trigger(pick_type(), pick_mask(), 1'b0);
        send_trigger(pick_type(), pick_mask(), 1'b1);  // one cycle later, lost
        wait_readouts(8);
        send_trigger(pick_type(), pick_mask(), 1'b0);  // number skips one
        wait_readouts(9);

        rst_trigger_num = 1'b1;
        @(negedge ttc_clk);
        rst_trigger_num = 1'b0;
        glob_cnt        = '0;
        evt_cnt         = '0;
        send_trigger(pick_type(), pick_mask(), 1'b0);
        wait_readouts(10);

        readout_ready = 1'b0;  // command manager busy, fifos fill
        for (i = 0; i < 4; i++) begin
            send_trigger(pick_type(), pick_mask(), 1'b0);
            wait_acq_done();
            // i + 1 entries in each fifo, flag at one free slot or none
            check_flag(trig_fifo_full, (i + 1 >= FIFO_DEPTH - 1), "trig_fifo_full");
            check_flag(acq_fifo_full, (i + 1 >= FIFO_DEPTH - 1), "acq_fifo_full");
        end
        readout_ready = 1'b1;
        wait_readouts(14);
        repeat (20) @(negedge ttc_clk);

        if (stim_q.size() != 0 || fire_q.size() != 0)
            abort_run("some triggers never produced a readout or channel trigger");
        if (i_dut.i_assert.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "port assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== dv/trigger_top_assert.sv ====
// trigger manager port assertions
`timescale 1ns/1ps
`default_nettype none

module trigger_top_assert (
    input  wire                          ttc_clk,
    input  wire                          rst,
    input  wire trigger_pkg::chan_mask_t chan_enable,
    input  wire trigger_pkg::chan_mask_t chan_trig,
    input  wire                          initiate_readout,
    input  wire                          send_empty_event,
    input  wire                          error_trig_rate,
    input  wire                          error_trig_num,
    input  wire                          error_trig_type,
    input  wire                          trig_fifo_full,
    input  wire                          acq_fifo_full
);

    int fail_count = 0;  // polled by the testbench

    // --------------------
    // channel triggers
    // --------------------
    trig_within_enable: assert property (@(posedge ttc_clk) disable iff (rst)
        (chan_trig & ~chan_enable) == '0)
        else begin
            fail_count = fail_count + 1;
            $error("chan_trig set on a disabled channel");
        end

    trig_single_cycle: assert property (@(posedge ttc_clk) disable iff (rst)
        (chan_trig != '0) |=> (chan_trig == '0))
        else begin
            fail_count = fail_count + 1;
            $error("chan_trig held for more than one cycle");
        end

    // only one kind of request at a time
    req_exclusive: assert property (@(posedge ttc_clk) disable iff (rst)
        !(initiate_readout && send_empty_event))
        else begin
            fail_count = fail_count + 1;
            $error("initiate_readout and send_empty_event both high");
        end

    // everything quiet right after reset
    reset_quiet: assert property (@(posedge ttc_clk)
        rst |=> (chan_trig == '0 && chan_enable == '0 && !initiate_readout
                 && !send_empty_event && !error_trig_rate && !error_trig_num
                 && !error_trig_type && !trig_fifo_full && !acq_fifo_full))
        else begin
            fail_count = fail_count + 1;
            $error("control outputs not cleared by reset");
        end

endmodule

bind trigger_top trigger_top_assert i_assert (
    .ttc_clk          (ttc_clk),
    .rst              (rst),
    .chan_enable      (chan_enable),
    .chan_trig        (chan_trig),
    .initiate_readout (initiate_readout),
    .send_empty_event (send_empty_event),
    .error_trig_rate  (error_trig_rate),
    .error_trig_num   (error_trig_num),
    .error_trig_type  (error_trig_type),
    .trig_fifo_full   (trig_fifo_full),
    .acq_fifo_full    (acq_fifo_full)
);

`default_nettype wire

// ==== verilog/trigger_top.sv ====
// trigger manager top level
`timescale 1ns/1ps
`default_nettype none

module trigger_top #(
    parameter int FIFO_DEPTH = 16  // both fifos, power of two
) (
    input  wire                      ttc_clk,          // TTC clock, only domain
    input  wire                      rst,
    input  wire                      rst_trigger_num,

    // trigger configuration
    input  wire                      ttc_trigger,
    input  wire trigger_pkg::trig_type_t trig_type,
    input  wire trigger_pkg::chan_mask_t chan_en,
    input  wire trigger_pkg::delay_t trig_delay,

    // channels
    input  wire trigger_pkg::chan_mask_t chan_dones,
    output trigger_pkg::chan_mask_t  chan_enable,
    output trigger_pkg::chan_mask_t  chan_trig,

    // command manager
    input  wire                      readout_ready,
    input  wire                      readout_done,
    output logic                     initiate_readout,
    output logic                     send_empty_event,
    output trigger_pkg::trig_info_t  readout_info,

    // status and errors
    output trigger_pkg::trig_num_t   trig_num,
    output logic                     trig_fifo_full,   // almost full
    output logic                     acq_fifo_full,    // almost full
    output logic                     error_trig_rate,
    output logic                     error_trig_num,
    output logic                     error_trig_type
);

    import trigger_pkg::*;

    // --------------------
    // wires
    // --------------------
    logic       acq_ready;        // receiver <-> controller
    logic       acq_trigger;
    acq_event_t acq_event;

    logic       trig_wr_valid;    // trigger fifo
    logic       trig_wr_ready;
    trig_info_t trig_wr_data;
    logic       trig_rd_valid;
    logic       trig_rd_ready;
    trig_info_t trig_rd_data;

    logic       acq_wr_valid;     // acquisition fifo
    logic       acq_wr_ready;
    acq_event_t acq_wr_data;
    logic       acq_rd_valid;
    logic       acq_rd_ready;
    acq_event_t acq_rd_data;

    // --------------------
    // instances
    // --------------------
    ttc_trigger_receiver ttc_trigger_receiver (
        .ttc_clk         (ttc_clk),
        .rst             (rst),
        .rst_trigger_num (rst_trigger_num),
        .ttc_trigger     (ttc_trigger),
        .trig_type       (trig_type),
        .chan_en         (chan_en),
        .acq_ready       (acq_ready),
        .acq_trigger     (acq_trigger),
        .acq_event       (acq_event),
        .fifo_ready      (trig_wr_ready),
        .fifo_valid      (trig_wr_valid),
        .fifo_data       (trig_wr_data),
        .trig_num        (trig_num),
        .error_trig_rate (error_trig_rate)
    );

    // timestamps, numbers and type of accepted triggers
    trigger_fifo #(
        .payload_t (trig_info_t),
        .DEPTH     (FIFO_DEPTH)
    ) ttc_trigger_fifo (
        .ttc_clk     (ttc_clk),
        .rst         (rst),
        .wr_valid    (trig_wr_valid),
        .wr_data     (trig_wr_data),
        .wr_ready    (trig_wr_ready),
        .rd_valid    (trig_rd_valid),
        .rd_ready    (trig_rd_ready),
        .rd_data     (trig_rd_data),
        .almost_full (trig_fifo_full)
    );

    channel_acq_controller channel_acq_controller (
        .ttc_clk     (ttc_clk),
        .rst         (rst),
        .trig_delay  (trig_delay),
        .acq_trigger (acq_trigger),
        .acq_event   (acq_event),
        .acq_ready   (acq_ready),
        .chan_dones  (chan_dones),
        .chan_enable (chan_enable),
        .chan_trig   (chan_trig),
        .fifo_ready  (acq_wr_ready),
        .fifo_valid  (acq_wr_valid),
        .fifo_data   (acq_wr_data)
    );

    // completed acquisitions
    trigger_fifo #(
        .payload_t (acq_event_t),
        .DEPTH     (FIFO_DEPTH)
    ) acq_event_fifo (
        .ttc_clk     (ttc_clk),
        .rst         (rst),
        .wr_valid    (acq_wr_valid),
        .wr_data     (acq_wr_data),
        .wr_ready    (acq_wr_ready),
        .rd_valid    (acq_rd_valid),
        .rd_ready    (acq_rd_ready),
        .rd_data     (acq_rd_data),
        .almost_full (acq_fifo_full)
    );

    trigger_processor trigger_processor (
        .ttc_clk          (ttc_clk),
        .rst              (rst),
        .trig_valid       (trig_rd_valid),
        .trig_data        (trig_rd_data),
        .trig_rd          (trig_rd_ready),
        .acq_valid        (acq_rd_valid),
        .acq_data         (acq_rd_data),
        .acq_rd           (acq_rd_ready),
        .readout_ready    (readout_ready),
        .readout_done     (readout_done),
        .initiate_readout (initiate_readout),
        .send_empty_event (send_empty_event),
        .readout_info     (readout_info),
        .error_trig_num   (error_trig_num),
        .error_trig_type  (error_trig_type)
    );

endmodule

`default_nettype wire

// ==== verilog/trigger_processor.sv ====
// trigger processor
`timescale 1ns/1ps
`default_nettype none

module trigger_processor (
    input  wire                      ttc_clk,
    input  wire                      rst,

    // trigger fifo read side
    input  wire                      trig_valid,
    input  wire trigger_pkg::trig_info_t trig_data,
    output logic                     trig_rd,

    // acquisition fifo read side
    input  wire                      acq_valid,
    input  wire trigger_pkg::acq_event_t acq_data,
    output logic                     acq_rd,

    // command manager
    input  wire                      readout_ready,    // cm idle
    input  wire                      readout_done,     // one-cycle pulse
    output logic                     initiate_readout,
    output logic                     send_empty_event,
    output trigger_pkg::trig_info_t  readout_info,     // held until done

    // sticky mismatch flags
    output logic                     error_trig_num,
    output logic                     error_trig_type
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT_DONE
    } state_t;

    state_t state;
    logic   pop;      // both fifos read together
    logic   empty_q;  // event had no channels enabled

    assign pop     = (state == ST_IDLE) && trig_valid && acq_valid && readout_ready;
    assign trig_rd = pop;
    assign acq_rd  = pop;

    // request pulse, the cycle after the pop
    assign initiate_readout = (state == ST_REQUEST) && !empty_q;
    assign send_empty_event = (state == ST_REQUEST) && empty_q;

    // --------------------
    // readout FSM
    // --------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) state <= ST_REQUEST;
                end
                ST_REQUEST: begin
                    state <= ST_WAIT_DONE;  // request is a single cycle
                end
                ST_WAIT_DONE: begin
                    if (readout_done) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // consistency of the pair
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            error_trig_num  <= 1'b0;
            error_trig_type <= 1'b0;
        end else if (pop) begin
            if (trig_data.event_num != acq_data.event_num) error_trig_num <= 1'b1;
            if (trig_data.trig_type != acq_data.trig_type) error_trig_type <= 1'b1;
        end
    end

    // descriptor, stable through the whole readout
    always_ff @(posedge ttc_clk) begin
        if (pop) begin
            readout_info <= trig_data;
            empty_q      <= (acq_data.chan_mask == '0);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/channel_acq_controller.sv ====
// channel acquisition controller
`timescale 1ns/1ps
`default_nettype none

module channel_acq_controller (
    input  wire                      ttc_clk,
    input  wire                      rst,
    input  wire trigger_pkg::delay_t trig_delay,      // cycles before chan_trig

    // from trigger receiver
    input  wire                      acq_trigger,
    input  wire trigger_pkg::acq_event_t acq_event,
    output logic                     acq_ready,

    // channel side
    input  wire trigger_pkg::chan_mask_t chan_dones,
    output trigger_pkg::chan_mask_t  chan_enable,
    output trigger_pkg::chan_mask_t  chan_trig,       // one-cycle pulse

    // to acquisition fifo
    input  wire                      fifo_ready,
    output logic                     fifo_valid,
    output trigger_pkg::acq_event_t  fifo_data
);

    import trigger_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DELAY,
        ST_WAIT_DONE,
        ST_LOG
    } state_t;

    state_t     state;
    delay_t     delay_cnt;  // cycles since acq_trigger
    acq_event_t event_q;    // event under acquisition
    logic       all_done;

    assign acq_ready  = (state == ST_IDLE) && fifo_ready;
    assign fifo_valid = (state == ST_LOG);
    assign fifo_data  = event_q;

    // disabled channels are ignored
    assign all_done = ((chan_dones & event_q.chan_mask) == event_q.chan_mask);

    // --------------------
    // control FSM
    // --------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            delay_cnt   <= '0;
            chan_enable <= '0;
            chan_trig   <= '0;
        end else begin
            chan_trig <= '0;  // default, pulse lasts one cycle
            case (state)
                ST_IDLE: begin
                    if (acq_trigger) begin
                        chan_enable <= acq_event.chan_mask;
                        delay_cnt   <= delay_t'(1);
                        if (acq_event.chan_mask == '0) begin
                            state <= ST_LOG;  // empty event, nothing to fire
                        end else if (trig_delay == '0) begin
                            chan_trig <= acq_event.chan_mask;
                            state     <= ST_WAIT_DONE;
                        end else begin
                            state <= ST_DELAY;
                        end
                    end
                end
                ST_DELAY: begin
                    if (delay_cnt == trig_delay) begin
                        chan_trig <= chan_enable;  // enabled bits only
                        state     <= ST_WAIT_DONE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                ST_WAIT_DONE: begin
                    if (all_done) state <= ST_LOG;
                end
                ST_LOG: begin
                    if (fifo_ready) begin
                        chan_enable <= '0;  // write done, release channels
                        state       <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // event held for the log write
    always_ff @(posedge ttc_clk) begin
        if (state == ST_IDLE && acq_trigger) begin
            event_q <= acq_event;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ttc_trigger_receiver.sv ====
// TTC trigger receiver
`timescale 1ns/1ps
`default_nettype none

module ttc_trigger_receiver (
    input  wire                      ttc_clk,
    input  wire                      rst,
    input  wire                      rst_trigger_num,  // TTC channel B command

    // trigger input
    input  wire                      ttc_trigger,
    input  wire trigger_pkg::trig_type_t trig_type,
    input  wire trigger_pkg::chan_mask_t chan_en,

    // to acquisition controller
    input  wire                      acq_ready,
    output logic                     acq_trigger,      // one-cycle pulse
    output trigger_pkg::acq_event_t  acq_event,

    // to trigger fifo
    input  wire                      fifo_ready,
    output logic                     fifo_valid,
    output trigger_pkg::trig_info_t  fifo_data,

    // status
    output trigger_pkg::trig_num_t   trig_num,         // global trigger count
    output logic                     error_trig_rate   // sticky
);

    import trigger_pkg::*;

    timestamp_t timestamp;      // free running
    trig_num_t  event_num;      // accepted triggers
    trig_num_t  trig_num_nxt;
    trig_num_t  event_num_nxt;
    logic       trig_in;
    logic       accept;

    // a counter reset wins over a coincident trigger
    assign trig_in = ttc_trigger && !rst_trigger_num;

    // write still pending from the last cycle means no room downstream yet
    assign accept = trig_in && acq_ready && fifo_ready && !acq_trigger;

    assign trig_num_nxt  = trig_num + 1'b1;
    assign event_num_nxt = event_num + 1'b1;

    assign fifo_valid = acq_trigger;  // fifo write rides with the pulse

    // --------------------
    // counters
    // --------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst || rst_trigger_num) begin
            trig_num  <= '0;  // next trigger gets 1
            event_num <= '0;
        end else if (trig_in) begin
            trig_num <= trig_num_nxt;  // dropped ones still count
            if (accept) event_num <= event_num_nxt;
        end
    end

    // --------------------
    // acceptance
    // --------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            acq_trigger     <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            acq_trigger <= accept;
            if (trig_in && !accept) error_trig_rate <= 1'b1;  // downstream busy
        end
    end

    // payloads for both consumers
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            fifo_data.timestamp <= timestamp;
            fifo_data.trig_num  <= trig_num_nxt;
            fifo_data.event_num <= event_num_nxt;
            fifo_data.trig_type <= trig_type;
            acq_event.event_num <= event_num_nxt;
            acq_event.trig_type <= trig_type;
            acq_event.chan_mask <= chan_en;  // mask sampled with the trigger
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trigger_fifo.sv ====
// synchronous fall-through fifo
`timescale 1ns/1ps
`default_nettype none

module trigger_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16  // power of two, 4 or more
) (
    input  wire           ttc_clk,
    input  wire           rst,

    // write side
    input  wire           wr_valid,
    input  wire payload_t wr_data,
    output logic          wr_ready,     // low when full

    // read side
    output logic          rd_valid,
    input  wire           rd_ready,
    output payload_t      rd_data,      // valid with rd_valid

    output logic          almost_full   // one free slot or none
);

    localparam int            AW        = $clog2(DEPTH);
    localparam logic [AW:0]   FULL_CNT  = (AW+1)'(DEPTH);
    localparam logic [AW:0]   AFULL_CNT = (AW+1)'(DEPTH - 1);

    payload_t      mem [DEPTH];  // storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;        // occupancy
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    assign wr_ready    = (count != FULL_CNT);
    assign rd_valid    = (count != '0);
    assign almost_full = (count >= AFULL_CNT);
    assign rd_data     = mem[rd_ptr];  // head of queue, no read latency

    always_ff @(posedge ttc_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap naturally on a power-of-two depth
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trigger_pkg.sv ====
// trigger manager shared types
`default_nettype none

package trigger_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int CHAN_NUM    = 5;   // digitizer channels
    localparam int TRIG_NUM_W  = 24;
    localparam int TIMESTAMP_W = 44;
    localparam int DELAY_W     = 32;

    typedef logic [CHAN_NUM-1:0]    chan_mask_t;  // one bit per channel
    typedef logic [TRIG_NUM_W-1:0]  trig_num_t;   // first trigger is 1
    typedef logic [TIMESTAMP_W-1:0] timestamp_t;  // free-running ttc_clk count
    typedef logic [DELAY_W-1:0]     delay_t;      // in ttc_clk cycles

    // trigger type from the TTC decoder
    typedef enum logic [2:0] {
        TRIG_MUON_FILL     = 3'b001,
        TRIG_LASER         = 3'b010,
        TRIG_PEDESTAL      = 3'b011,
        TRIG_ASYNC_READOUT = 3'b111  // remaining codes reserved
    } trig_type_t;

    // --------------------
    // fifo payloads
    // --------------------

    // trigger fifo entry and readout descriptor, 95 bits
    typedef struct packed {
        timestamp_t timestamp;  // cycle count at the sampling edge
        trig_num_t  trig_num;   // global, counts dropped triggers too
        trig_num_t  event_num;  // accepted triggers only
        trig_type_t trig_type;
    } trig_info_t;

    // acquisition fifo entry, 32 bits
    typedef struct packed {
        trig_num_t  event_num;
        trig_type_t trig_type;
        chan_mask_t chan_mask;  // channels enabled for this event
    } acq_event_t;

endpackage

`default_nettype wire
